// File: src.f
src/cachePkg.sv
src/cacheDataRam.sv
src/cacheTagArray.sv
src/cacheRefill.sv
src/cacheCtrl.sv
src/cacheTop.sv
testbench/memModel.sv
testbench/tbCache.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tbCache -o simCache
./obj_dir/simCache | tee sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
else
  exit 1
fi

// File: testbench/tbCache.sv
`timescale 1ns/10ps

module tbCache import cachePkg::*; ();

  localparam int AcceptTimeout = 200;
  localparam int DrainTimeout  = 400;
  localparam int RandomCount   = 48;

  localparam logic [1:0] AnyKind = 2'd0;
  localparam logic [1:0] ExpMiss = 2'd1;
  localparam logic [1:0] ExpHit  = 2'd2;

  // table row with address, idle cycles before it and expected hit or miss
  typedef struct packed {
    addrT       addr;
    logic [3:0] gap;
    logic [1:0] kind;
  } stimT;

  typedef struct packed {
    wordT        data;
    logic        hit;
    logic [31:0] acceptEdge;
  } expT;

  logic clk = 1'b0;
  logic rst_n;
  logic valid_i;
  addrT addr_i;
  logic addrOk_o;
  logic dataOk_o;
  wordT rdData_o;
  logic rdValid_o;
  addrT rdAddr_o;
  logic rdBeatValid_i;
  logic rdLast_i;
  wordT rdData_i;

  integer      seed = 37108;
  int          errCnt = 0;
  int          fetchCnt = 0;
  int          hitCnt = 0;
  int          missCnt = 0;
  logic [31:0] edgeCnt = '0;
  logic        prevRdValid = 1'b0;
  logic        lastHit = 1'b0;

  stimT stimTab[$];
  expT  expQ[$];
  addrT missQ[$];

  // reference model state
  tagT  mTag[2][Sets];
  logic mValid[2][Sets];
  wayT  mLru[Sets];

  cacheTop dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .rdBeatValid_i (rdBeatValid_i),
    .rdLast_i      (rdLast_i),
    .rdData_i      (rdData_i)
  );

  memModel mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .rdValid_i     (rdValid_o),
    .rdAddr_i      (rdAddr_o),
    .rdBeatValid_o (rdBeatValid_i),
    .rdLast_o      (rdLast_i),
    .rdData_o      (rdData_i)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    edgeCnt <= edgeCnt + 1;
  end

  function automatic addrT makeAddr(input tagT tag, input indexT idx, input logic [1:0] word);
    makeAddr = {tag, idx, word, 3'b000};
  endfunction

  // memory word for a byte address
  function automatic wordT memWord(input addrT a);
    addrT wa;
    wa = {a[AddrWidth-1:3], 3'b000};
    memWord = {~wa, wa};
  endfunction

  task automatic addEntry(input addrT a, input int gap, input logic [1:0] kind);
    stimT s;
    s.addr = a;
    s.gap  = gap[3:0];
    s.kind = kind;
    stimTab.push_back(s);
  endtask

  task automatic buildTable();
    int   n;
    logic [31:0] r;
    // cold miss, then a lone hit for the latency
    addEntry(makeAddr(1, 3, 2), 2, ExpMiss);
    addEntry(makeAddr(1, 3, 0), 3, ExpHit);
    // back to back hits on one line
    addEntry(makeAddr(1, 3, 1), 2, ExpHit);
    addEntry(makeAddr(1, 3, 3), 0, ExpHit);
    addEntry(makeAddr(1, 3, 0), 0, ExpHit);
    // second tag of set 3 goes to way 1
    addEntry(makeAddr(2, 3, 0), 1, ExpMiss);
    addEntry(makeAddr(1, 3, 2), 0, ExpHit);
    addEntry(makeAddr(2, 3, 1), 0, ExpHit);
    addEntry(makeAddr(1, 3, 0), 0, ExpHit);
    // tag 2 is lru, tag 5 replaces it
    addEntry(makeAddr(5, 3, 0), 1, ExpMiss);
    addEntry(makeAddr(1, 3, 3), 0, ExpHit);
    addEntry(makeAddr(2, 3, 2), 0, ExpMiss);
    addEntry(makeAddr(5, 3, 1), 0, ExpMiss);
    addEntry(makeAddr(1, 3, 1), 0, ExpMiss);
    // hits across two sets with no gap
    addEntry(makeAddr(7, 10, 1), 2, ExpMiss);
    addEntry(makeAddr(7, 10, 3), 0, ExpHit);
    addEntry(makeAddr(1, 3, 1), 0, ExpHit);
    addEntry(makeAddr(5, 3, 2), 0, ExpHit);
    addEntry(makeAddr(7, 10, 0), 0, ExpHit);
    addEntry(makeAddr(2, 3, 0), 1, ExpMiss);
    // random traffic over four tags and two sets
    for (n = 0; n < RandomCount; n++) begin
      r = $random(seed);
      addEntry({19'd0, r[1:0], 5'b10100, r[2], r[4:3], r[7:5]}, r[9:8], AnyKind);
    end
  endtask

  // reference cache updated in acceptance order
  task automatic predict(input stimT s, input logic [31:0] accEdge);
    tagT   tag;
    indexT idx;
    wayT   way;
    logic  hit;
    expT   e;
    tag = s.addr[AddrWidth-1 -: TagWidth];
    idx = s.addr[OffsetWidth +: IndexWidth];
    hit = 1'b0;
    way = 1'b0;
    if (mValid[0][idx] && mTag[0][idx] == tag) begin
      hit = 1'b1;
    end else if (mValid[1][idx] && mTag[1][idx] == tag) begin
      hit = 1'b1;
      way = 1'b1;
    end
    if (!hit) begin
      if (!mValid[0][idx]) begin
        way = 1'b0;
      end else if (!mValid[1][idx]) begin
        way = 1'b1;
      end else begin
        way = mLru[idx];
      end
      mTag[way][idx]   = tag;
      mValid[way][idx] = 1'b1;
      missQ.push_back({tag, idx, {OffsetWidth{1'b0}}});
      missCnt++;
    end else begin
      hitCnt++;
    end
    mLru[idx] = ~way;
    lastHit   = hit;
    if ((s.kind == ExpHit && !hit) || (s.kind == ExpMiss && hit)) begin
      $display("Table and reference model disagree on hit for address %h", s.addr);
      errCnt++;
    end
    e.data       = memWord(s.addr);
    e.hit        = hit;
    e.acceptEdge = accEdge;
    expQ.push_back(e);
  endtask

  // returns right after the edge that takes the request
  task automatic waitAccept(input stimT s, input logic mustTake, output logic ok);
    int          waitCnt;
    logic        taken;
    logic [31:0] accEdge;
    waitCnt = 0;
    taken   = 1'b0;
    accEdge = '0;
    while (!taken && waitCnt < AcceptTimeout) begin
      @(negedge clk);
      if (addrOk_o) begin
        taken   = 1'b1;
        accEdge = edgeCnt + 1;
      end else if (mustTake && waitCnt == 0) begin
        // a request right after a hit is never held off
        $display("** Error at %0t: addrOk_o = %b, expected 1", $time, addrOk_o);
        errCnt++;
      end
      @(posedge clk);
      waitCnt++;
    end
    ok = taken;
    if (taken) begin
      predict(s, accEdge);
    end else begin
      $display("Request for address %h not accepted within %0d cycles", s.addr, AcceptTimeout);
      errCnt++;
    end
  endtask

  // returned data and hit latency
  always @(negedge clk) begin
    expT e;
    if (rst_n === 1'b1 && dataOk_o) begin
      if (expQ.size() == 0) begin
        $display("dataOk_o pulsed at %0t with no request outstanding", $time);
        errCnt++;
      end else begin
        e = expQ.pop_front();
        if (rdData_o !== e.data) begin
          $display("** Error at %0t: rdData_o = %h, expected %h", $time, rdData_o, e.data);
          errCnt++;
        end
        // result sampled by the second edge after acceptance
        if (e.hit && edgeCnt + 1 - e.acceptEdge != 2) begin
          $display("** Error at %0t: dataOk_o latency = %0d edges, expected 2",
                   $time, edgeCnt + 1 - e.acceptEdge);
          errCnt++;
        end
      end
    end
  end

  // each fetch start must match a predicted miss
  always @(negedge clk) begin
    addrT lineAddr;
    if (rst_n === 1'b1 && rdValid_o && !prevRdValid) begin
      fetchCnt++;
      if (missQ.size() == 0) begin
        $display("Unexpected line fetch of %h at %0t", rdAddr_o, $time);
        errCnt++;
      end else begin
        lineAddr = missQ.pop_front();
        if (rdAddr_o !== lineAddr) begin
          $display("** Error at %0t: rdAddr_o = %h, expected %h", $time, rdAddr_o, lineAddr);
          errCnt++;
        end
      end
    end
    prevRdValid <= rdValid_o;
  end

  initial begin
    int   i;
    int   waitCnt;
    logic ok;
    rst_n   = 1'b0;
    valid_i = 1'b0;
    addr_i  = '0;
    for (i = 0; i < Sets; i++) begin
      mValid[0][i] = 1'b0;
      mValid[1][i] = 1'b0;
      mLru[i]      = 1'b0;
    end
    buildTable();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dataOk_o !== 1'b0) begin
      $display("** Error at %0t: dataOk_o = %b, expected 0", $time, dataOk_o);
      errCnt++;
    end
    if (rdValid_o !== 1'b0) begin
      $display("** Error at %0t: rdValid_o = %b, expected 0", $time, rdValid_o);
      errCnt++;
    end
    if (addrOk_o !== 1'b1) begin
      $display("** Error at %0t: addrOk_o = %b, expected 1", $time, addrOk_o);
      errCnt++;
    end
    @(posedge clk);
    ok = 1'b1;
    for (i = 0; i < stimTab.size() && ok; i++) begin
      if (stimTab[i].gap != 0) begin
        valid_i <= 1'b0;
        repeat (stimTab[i].gap) @(posedge clk);
      end
      valid_i <= 1'b1;
      addr_i  <= stimTab[i].addr;
      waitAccept(stimTab[i], lastHit, ok);
    end
    valid_i <= 1'b0;
    waitCnt = 0;
    while (expQ.size() != 0 && waitCnt < DrainTimeout) begin
      @(posedge clk);
      waitCnt++;
    end
    if (expQ.size() != 0) begin
      $display("Timed out with %0d results still outstanding", expQ.size());
      errCnt++;
    end
    if (missQ.size() != 0) begin
      $display("%0d predicted line fetches never started", missQ.size());
      errCnt++;
    end
    $display("Summary: %0d requests, %0d hits, %0d misses, %0d fetches, %0d errors",
             hitCnt + missCnt, hitCnt, missCnt, fetchCnt, errCnt);
    if (errCnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: testbench/memModel.sv
`timescale 1ns/10ps

module memModel import cachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic rdValid_i,
  input  addrT rdAddr_i,
  output logic rdBeatValid_o,
  output logic rdLast_o,
  output wordT rdData_o
);

  integer seed = 37108;

  logic       busy;
  logic       drain;
  logic [1:0] beat;
  logic [1:0] gapCnt;
  addrT       lineAddr;

  // inverted byte address on top, byte address below
  function automatic wordT beatData(input addrT base, input logic [1:0] idx);
    addrT a;
    a = base + {27'd0, idx, 3'b000};
    beatData = {~a, a};
  endfunction

  function automatic logic [1:0] randGap();
    integer r;
    r = $random(seed);
    randGap = r[1:0];
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= 1'b0;
      drain         <= 1'b0;
      beat          <= 2'd0;
      gapCnt        <= 2'd0;
      lineAddr      <= '0;
      rdBeatValid_o <= 1'b0;
      rdLast_o      <= 1'b0;
      rdData_o      <= '0;
    end else begin
      rdBeatValid_o <= 1'b0;
      rdLast_o      <= 1'b0;
      if (drain) begin
        // request level still seen high on the edge that takes the last beat
        if (!rdValid_i) begin
          drain <= 1'b0;
        end
      end else if (!busy) begin
        if (rdValid_i) begin
          busy     <= 1'b1;
          beat     <= 2'd0;
          lineAddr <= rdAddr_i;
          gapCnt   <= randGap();
        end
      end else if (gapCnt != 2'd0) begin
        gapCnt <= gapCnt - 2'd1;
      end else begin
        rdBeatValid_o <= 1'b1;
        rdData_o      <= beatData(lineAddr, beat);
        if (beat == 2'd3) begin
          rdLast_o <= 1'b1;
          busy     <= 1'b0;
          drain    <= 1'b1;
        end
        beat   <= beat + 2'd1;
        gapCnt <= randGap();
      end
    end
  end

endmodule

// File: src/cacheTop.sv
`timescale 1ns/10ps

module cacheTop import cachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  // pipeline side
  input  logic valid_i,
  input  addrT addr_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output wordT rdData_o,
  // memory side
  output logic rdValid_o,
  output addrT rdAddr_o,
  input  logic rdBeatValid_i,
  input  logic rdLast_i,
  input  wordT rdData_i
);

  logic     lookupEn;
  indexT    lookupIndex;
  tagRdT    tagRd;
  lineT     way0Line;
  lineT     way1Line;
  arrayWrT  arrayWr;
  lruTouchT lruTouch;
  logic     refillStart;
  addrT     refillAddr;
  lineT     refillLine;
  logic     refillDone;

  cacheCtrl ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .lookupEn_o    (lookupEn),
    .lookupIndex_o (lookupIndex),
    .tagRd_i       (tagRd),
    .way0Line_i    (way0Line),
    .way1Line_i    (way1Line),
    .arrayWr_o     (arrayWr),
    .lruTouch_o    (lruTouch),
    .refillStart_o (refillStart),
    .refillAddr_o  (refillAddr),
    .refillLine_i  (refillLine),
    .refillDone_i  (refillDone)
  );

  cacheTagArray tags (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdEn_i    (lookupEn),
    .rdIndex_i (lookupIndex),
    .tagRd_o   (tagRd),
    .wr_i      (arrayWr),
    .touch_i   (lruTouch)
  );

  // write enable follows the fill way
  cacheDataRam way0Ram (
    .clk      (clk),
    .en_i     (lookupEn),
    .we_i     (arrayWr.en && !arrayWr.way),
    .index_i  (lookupIndex),
    .wrLine_i (arrayWr.line),
    .rdLine_o (way0Line)
  );

  cacheDataRam way1Ram (
    .clk      (clk),
    .en_i     (lookupEn),
    .we_i     (arrayWr.en && arrayWr.way),
    .index_i  (lookupIndex),
    .wrLine_i (arrayWr.line),
    .rdLine_o (way1Line)
  );

  cacheRefill refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (refillStart),
    .lineAddr_i    (refillAddr),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .rdBeatValid_i (rdBeatValid_i),
    .rdLast_i      (rdLast_i),
    .rdData_i      (rdData_i),
    .line_o        (refillLine),
    .done_o        (refillDone)
  );

endmodule

// File: src/cacheCtrl.sv
`timescale 1ns/10ps

module cacheCtrl import cachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // pipeline side
  input  logic     valid_i,
  input  addrT     addr_i,
  output logic     addrOk_o,
  output logic     dataOk_o,
  output wordT     rdData_o,
  // array lookup
  output logic     lookupEn_o,
  output indexT    lookupIndex_o,
  input  tagRdT    tagRd_i,
  input  lineT     way0Line_i,
  input  lineT     way1Line_i,
  // array updates
  output arrayWrT  arrayWr_o,
  output lruTouchT lruTouch_o,
  // line fetch
  output logic     refillStart_o,
  output addrT     refillAddr_o,
  input  lineT     refillLine_i,
  input  logic     refillDone_i
);

  cacheStateT stateQ;
  cacheStateT stateD;

  addrT reqAddrQ;
  wayT  victimQ;
  logic dataOkQ;
  wordT rdDataQ;

  tagT                     reqTag;
  indexT                   reqIndex;
  logic [BeatIdxWidth-1:0] reqWord;

  logic accept;
  logic way0Hit;
  logic way1Hit;
  logic hit;
  logic fillNow;
  wayT  victim;

  function automatic wordT pickWord(lineT line, logic [BeatIdxWidth-1:0] sel);
    pickWord = line[sel*XLen +: XLen];
  endfunction

  // fields of the request under compare or refill
  assign reqTag   = reqAddrQ[AddrWidth-1 -: TagWidth];
  assign reqIndex = reqAddrQ[OffsetWidth +: IndexWidth];
  assign reqWord  = reqAddrQ[OffsetWidth-1 -: BeatIdxWidth];

  assign way0Hit = (stateQ == Compare) && tagRd_i.valid0 && (tagRd_i.tag0 == reqTag);
  assign way1Hit = (stateQ == Compare) && tagRd_i.valid1 && (tagRd_i.tag1 == reqTag);
  assign hit     = way0Hit || way1Hit;

  // invalid way first, then the lru way
  always_comb begin
    if (!tagRd_i.valid0) begin
      victim = 1'b0;
    end else if (!tagRd_i.valid1) begin
      victim = 1'b1;
    end else begin
      victim = tagRd_i.lru;
    end
  end

  assign addrOk_o = (stateQ == Idle) || hit;
  assign accept   = valid_i && addrOk_o;
  assign fillNow  = (stateQ == Refill) && refillDone_i;

  // during refill the index port carries the fill index for the data RAMs
  assign lookupEn_o    = accept;
  assign lookupIndex_o = (stateQ == Refill) ? reqIndex
                                            : addr_i[OffsetWidth +: IndexWidth];

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (accept) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (!hit) begin
          stateD = Refill;
        end else if (!accept) begin
          stateD = Idle;
        end
      end
      Refill: begin
        if (refillDone_i) begin
          stateD = Idle;
        end
      end
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ  <= Idle;
      dataOkQ <= 1'b0;
      victimQ <= 1'b0;
    end else begin
      stateQ  <= stateD;
      dataOkQ <= hit || fillNow;
      if (stateQ == Compare && !hit) begin
        victimQ <= victim;
      end
    end
  end

  // request latch and returned word
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddrQ <= addr_i;
    end
    if (hit) begin
      rdDataQ <= pickWord(way1Hit ? way1Line_i : way0Line_i, reqWord);
    end else if (fillNow) begin
      rdDataQ <= pickWord(refillLine_i, reqWord);
    end
  end

  assign dataOk_o = dataOkQ;
  assign rdData_o = rdDataQ;

  // fetch starts straight out of compare on a miss
  assign refillStart_o = (stateQ == Compare) && !hit;
  assign refillAddr_o  = {reqTag, reqIndex, {OffsetWidth{1'b0}}};

  assign lruTouch_o.en    = hit;
  assign lruTouch_o.index = reqIndex;
  assign lruTouch_o.way   = way1Hit;

  assign arrayWr_o.en    = fillNow;
  assign arrayWr_o.way   = victimQ;
  assign arrayWr_o.index = reqIndex;
  assign arrayWr_o.tag   = reqTag;
  assign arrayWr_o.line  = refillLine_i;

endmodule

// File: src/cacheRefill.sv
`timescale 1ns/10ps

module cacheRefill import cachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  addrT lineAddr_i,
  output logic rdValid_o,
  output addrT rdAddr_o,
  input  logic rdBeatValid_i,
  input  logic rdLast_i,
  input  wordT rdData_i,
  output lineT line_o,
  output logic done_o
);

  logic                    busyQ;
  logic                    doneQ;
  logic [BeatIdxWidth-1:0] beatCntQ;
  addrT                    addrQ;
  lineT                    lineQ;

  logic beatTake;

  // beats only count while a fetch is open
  assign beatTake = busyQ && rdBeatValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busyQ    <= 1'b0;
      doneQ    <= 1'b0;
      beatCntQ <= '0;
    end else begin
      doneQ <= 1'b0;
      if (start_i) begin
        busyQ    <= 1'b1;
        beatCntQ <= '0;
      end else if (beatTake) begin
        beatCntQ <= beatCntQ + 1'b1;
        if (rdLast_i) begin
          busyQ <= 1'b0;
          doneQ <= 1'b1;
        end
      end
    end
  end

  // line address and assembled data
  always_ff @(posedge clk) begin
    if (start_i) begin
      addrQ <= lineAddr_i;
    end
    if (beatTake) begin
      lineQ[beatCntQ*XLen +: XLen] <= rdData_i;
    end
  end

  assign rdValid_o = busyQ;
  assign rdAddr_o  = addrQ;
  assign line_o    = lineQ;
  assign done_o    = doneQ;

endmodule

// File: src/cacheTagArray.sv
`timescale 1ns/10ps

module cacheTagArray import cachePkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rdEn_i,
  input  indexT    rdIndex_i,
  output tagRdT    tagRd_o,
  input  arrayWrT  wr_i,
  input  lruTouchT touch_i
);

  tagT tag0Mem [Sets];
  tagT tag1Mem [Sets];

  logic [Sets-1:0] valid0Q;
  logic [Sets-1:0] valid1Q;
  logic [Sets-1:0] lruQ;

  wayT lruRd;

  // a touch landing on the set being read must show up in this lookup
  assign lruRd = (touch_i.en && touch_i.index == rdIndex_i) ? ~touch_i.way
                                                           : lruQ[rdIndex_i];

  always_ff @(posedge clk) begin
    if (wr_i.en && wr_i.way == 1'b0) begin
      tag0Mem[wr_i.index] <= wr_i.tag;
    end
    if (wr_i.en && wr_i.way == 1'b1) begin
      tag1Mem[wr_i.index] <= wr_i.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0Q <= '0;
      valid1Q <= '0;
      lruQ    <= '0;
      tagRd_o <= '0;
    end else begin
      if (wr_i.en) begin
        if (wr_i.way == 1'b0) begin
          valid0Q[wr_i.index] <= 1'b1;
        end else begin
          valid1Q[wr_i.index] <= 1'b1;
        end
        // freshly filled way is most recent
        lruQ[wr_i.index] <= ~wr_i.way;
      end else if (touch_i.en) begin
        lruQ[touch_i.index] <= ~touch_i.way;
      end
      if (rdEn_i) begin
        tagRd_o.tag0   <= tag0Mem[rdIndex_i];
        tagRd_o.tag1   <= tag1Mem[rdIndex_i];
        tagRd_o.valid0 <= valid0Q[rdIndex_i];
        tagRd_o.valid1 <= valid1Q[rdIndex_i];
        tagRd_o.lru    <= lruRd;
      end
    end
  end

endmodule

// File: src/cacheDataRam.sv
`timescale 1ns/10ps

module cacheDataRam import cachePkg::*; (
  input  logic  clk,
  input  logic  en_i,
  input  logic  we_i,
  input  indexT index_i,
  input  lineT  wrLine_i,
  output lineT  rdLine_o
);

  // one full line per set
  lineT mem [Sets];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[index_i] <= wrLine_i;
    end
    // read data valid the cycle after en_i
    if (en_i) begin
      rdLine_o <= mem[index_i];
    end
  end

endmodule

// File: src/cachePkg.sv
package cachePkg;

  // address and data widths
  localparam int AddrWidth    = 32;
  localparam int XLen         = 64;
  localparam int LineWidth    = 256;

  // 64 sets of 32-byte lines in two ways
  localparam int Sets         = 64;
  localparam int BeatsPerLine = 4;
  localparam int BeatIdxWidth = $clog2(BeatsPerLine);

  // tag in bits 31..11, index in 10..5, offset in 4..0
  localparam int TagWidth     = 21;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;

  typedef logic [AddrWidth-1:0]  addrT;
  typedef logic [TagWidth-1:0]   tagT;
  typedef logic [IndexWidth-1:0] indexT;
  typedef logic [XLen-1:0]       wordT;
  // word 0 sits in the low bits
  typedef logic [LineWidth-1:0]  lineT;
  typedef logic                  wayT;

  typedef enum logic [1:0] {
    Idle,
    Compare,
    Refill
  } cacheStateT;

  // lookup result where lru names the way to evict next
  typedef struct packed {
    tagT  tag0;
    tagT  tag1;
    logic valid0;
    logic valid1;
    wayT  lru;
  } tagRdT;

  // line fill into one way
  typedef struct packed {
    logic  en;
    wayT   way;
    indexT index;
    tagT   tag;
    lineT  line;
  } arrayWrT;

  // lru update on a hit
  typedef struct packed {
    logic  en;
    indexT index;
    wayT   way;
  } lruTouchT;

endpackage
